/* rtl/tinker_pkg.sv */
// Widths, word types, opcode and FSM state enumerations for the Tinker core
package tinker_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int XLEN    = 64;   // Data word
    localparam int ILEN    = 32;   // Instruction word
    localparam int ALEN    = 32;   // Byte address
    localparam int RADDR_W = 5;    // 32 registers
    localparam int LIT_W   = 12;   // Literal field

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [ALEN-1:0]    addr_t;
    typedef logic [ILEN-1:0]    instr_t;
    typedef logic [RADDR_W-1:0] reg_addr_t;

    // ------------------------------------------------------------------------
    // Opcodes, instr[31:27]
    // ------------------------------------------------------------------------
    // Anything not listed decodes as a no-op
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,   // rt ignored
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BRR_L  = 5'h0A,   // PC + sext(L)
        OP_BRNZ   = 5'h0B,   // PC = rd if rs != 0
        OP_HALT   = 5'h0F,
        OP_LOAD   = 5'h10,   // rd = mem[rs + sext(L)]
        OP_MOV_R  = 5'h11,   // rd = rs
        OP_MOV_L  = 5'h12,   // rd[11:0] = L
        OP_STORE  = 5'h13,   // mem[rd + sext(L)] = rs
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1A,
        OP_SUBI   = 5'h1B
    } opcode_e;

    // Multicycle FSM
    typedef enum logic [2:0] {
        ST_FETCH     = 3'd0,
        ST_DECODE    = 3'd1,
        ST_EXECUTE   = 3'd2,
        ST_MEMORY    = 3'd3,
        ST_WRITEBACK = 3'd4,
        ST_HALT      = 3'd5   // Sticky until reset
    } state_e;

endpackage

/* rtl/tinker_alu.sv */
// Combinational integer ALU for the Tinker integer, shift and move opcodes
module tinker_alu (
    input  tinker_pkg::opcode_e          opcode,
    input  tinker_pkg::word_t            op_a,
    input  tinker_pkg::word_t            op_b,
    input  logic [tinker_pkg::LIT_W-1:0] literal,
    output tinker_pkg::word_t            result
);
    import tinker_pkg::*;

    word_t lit_sext;
    word_t lit_zext;

    assign lit_sext = {{(XLEN-LIT_W){literal[LIT_W-1]}}, literal};
    assign lit_zext = {{(XLEN-LIT_W){1'b0}}, literal};

    always_comb begin
        case (opcode)
            // Arithmetic
            OP_ADD:    result = op_a + op_b;
            OP_ADDI:   result = op_a + lit_sext;
            OP_SUB:    result = op_a - op_b;
            OP_SUBI:   result = op_a - lit_zext;   // Unsigned literal here
            // Logic
            OP_AND:    result = op_a & op_b;
            OP_OR:     result = op_a | op_b;
            OP_XOR:    result = op_a ^ op_b;
            OP_NOT:    result = ~op_a;
            // Logical shifts
            OP_SHFTR:  result = op_a >> op_b;
            OP_SHFTRI: result = op_a >> literal;
            OP_SHFTL:  result = op_a << op_b;
            OP_SHFTLI: result = op_a << literal;
            // Moves
            OP_MOV_R:  result = op_a;
            OP_MOV_L:  result = {op_a[XLEN-1:LIT_W], literal};   // Upper bits of rd kept
            default:   result = '0;
        endcase
    end

endmodule

/* rtl/tinker_regfile.sv */
// 32 x 64-bit register file, two async read ports, one write port, r0 fixed at zero
module tinker_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  tinker_pkg::reg_addr_t addr_a,
    input  tinker_pkg::reg_addr_t addr_b,
    output tinker_pkg::word_t     data_a,
    output tinker_pkg::word_t     data_b,
    input  logic                  we,
    input  tinker_pkg::reg_addr_t waddr,
    input  tinker_pkg::word_t     wdata
);
    import tinker_pkg::*;

    word_t regs [2**RADDR_W];

    assign data_a = regs[addr_a];
    assign data_b = regs[addr_b];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**RADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin   // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

endmodule

/* rtl/fetch_unit.sv */
// Instruction fetch unit with aligned word request and instruction register
module fetch_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  tinker_pkg::addr_t  pc,
    output logic               req,
    output tinker_pkg::addr_t  addr,
    input  tinker_pkg::word_t  rdata,
    input  logic               done,
    output tinker_pkg::instr_t instr
);
    import tinker_pkg::*;

    // Request held until the arbiter signals done
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req <= 1'b0;
        end else if (start) begin
            req <= 1'b1;
        end else if (done) begin
            req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr <= {pc[ALEN-1:3], 3'b000};   // Word holding the instruction
        end
        if (done) begin
            // Big-endian, pc[2] low picks the upper half
            instr <= pc[2] ? rdata[ILEN-1:0] : rdata[XLEN-1:ILEN];
        end
    end

endmodule

/* rtl/load_store_unit.sv */
// Load/store unit with effective address, single memory request and load data register
module load_store_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         store,
    input  tinker_pkg::word_t            base,         // rs for load, rd for store
    input  logic [tinker_pkg::LIT_W-1:0] literal,
    input  tinker_pkg::word_t            store_data,
    output logic                         req,
    output logic                         we,
    output tinker_pkg::addr_t            addr,
    output tinker_pkg::word_t            wdata,
    input  tinker_pkg::word_t            rdata,
    input  logic                         done,
    output tinker_pkg::word_t            load_data
);
    import tinker_pkg::*;

    addr_t eff_addr;

    // base + sext(L), truncated to the address width
    assign eff_addr = base[ALEN-1:0] + {{(ALEN-LIT_W){literal[LIT_W-1]}}, literal};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req <= 1'b0;
            we  <= 1'b0;
        end else if (start) begin
            req <= 1'b1;
            we  <= store;
        end else if (done) begin
            req <= 1'b0;
            we  <= 1'b0;
        end
    end

    // Request payload and loaded word
    always_ff @(posedge clk) begin
        if (start) begin
            addr  <= {eff_addr[ALEN-1:3], 3'b000};   // Doubleword aligned
            wdata <= store_data;
        end
        if (done && !we) begin
            load_data <= rdata;
        end
    end

endmodule

/* rtl/mem_arbiter.sv */
// Fixed-priority memory arbiter between the fetch unit and the load/store unit
module mem_arbiter (
    input  logic              clk,
    input  logic              reset,
    // Fetch side, read only
    input  logic              f_req,
    input  tinker_pkg::addr_t f_addr,
    output logic              f_done,
    // Data side
    input  logic              d_req,
    input  logic              d_we,
    input  tinker_pkg::addr_t d_addr,
    input  tinker_pkg::word_t d_wdata,
    output logic              d_done,
    // External port
    output logic              mem_req,
    output logic              mem_we,
    output tinker_pkg::addr_t mem_addr,
    output tinker_pkg::word_t mem_wdata,
    input  logic              mem_ready
);
    logic busy;      // Transfer waiting on mem_ready
    logic owner_d;   // Data side owns the waiting transfer
    logic sel_d;

    // Held grant wins, otherwise data side first
    assign sel_d = busy ? owner_d : d_req;

    assign mem_req   = sel_d ? d_req : f_req;
    assign mem_we    = sel_d & d_we;
    assign mem_addr  = sel_d ? d_addr : f_addr;
    assign mem_wdata = d_wdata;   // Only the data side writes

    // Done only to the current owner
    assign f_done = mem_req & mem_ready & ~sel_d;
    assign d_done = mem_req & mem_ready & sel_d;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
        end else begin
            busy    <= mem_req & ~mem_ready;
            owner_d <= sel_d;
        end
    end

endmodule

/* rtl/tinker_control.sv */
// Tinker FSM, program counter, field decode, operand steering and write-back control
module tinker_control #(
    parameter tinker_pkg::addr_t RESET_PC = 32'h0000_2000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  tinker_pkg::instr_t           instr,
    input  logic                         fetch_done,
    output logic                         fetch_start,
    input  tinker_pkg::word_t            rs_data,      // Read port A
    input  tinker_pkg::word_t            rt_data,      // Read port B
    output tinker_pkg::reg_addr_t        rf_addr_a,
    output tinker_pkg::reg_addr_t        rf_addr_b,
    input  tinker_pkg::word_t            alu_result,
    input  tinker_pkg::word_t            load_data,
    input  logic                         ls_done,
    output logic                         ls_start,
    output logic                         ls_store,
    output logic                         wb_en,
    output tinker_pkg::reg_addr_t        wb_addr,
    output tinker_pkg::word_t            wb_data,
    output tinker_pkg::opcode_e          opcode,
    output logic [tinker_pkg::LIT_W-1:0] literal,
    output tinker_pkg::addr_t            pc,
    output logic                         hlt
);
    import tinker_pkg::*;

    state_e    state;
    reg_addr_t rd;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     result_q;       // ALU result from EXECUTE
    logic      fetch_issued;   // Fetch request outstanding
    logic      is_mem;
    logic      writes_rd;
    addr_t     next_pc;

    // ------------------------------------------------------------------------
    // Field decode, same layout for every opcode
    // ------------------------------------------------------------------------
    assign opcode  = opcode_e'(instr[31:27]);
    assign rd      = instr[26:22];
    assign rs      = instr[21:17];
    assign rt      = instr[16:12];
    assign literal = instr[LIT_W-1:0];

    assign is_mem   = (opcode == OP_LOAD) || (opcode == OP_STORE);
    assign ls_store = (opcode == OP_STORE);

    // Register read steering
    always_comb begin
        rf_addr_a = rs;
        rf_addr_b = rt;
        case (opcode)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOV_L: rf_addr_a = rd;  // rd is source
            OP_STORE, OP_BRNZ: begin
                rf_addr_a = rd;   // Base or target
                rf_addr_b = rs;   // Data or condition
            end
            default: ;
        endcase
    end

    // Instructions that write rd
    always_comb begin
        case (opcode)
            OP_ADD, OP_ADDI, OP_SUB, OP_SUBI,
            OP_AND, OP_OR, OP_XOR, OP_NOT,
            OP_SHFTR, OP_SHFTRI, OP_SHFTL, OP_SHFTLI,
            OP_MOV_R, OP_MOV_L, OP_LOAD: writes_rd = 1'b1;
            default:                     writes_rd = 1'b0;
        endcase
    end

    // Next PC
    always_comb begin
        next_pc = pc + addr_t'(4);
        case (opcode)
            OP_BRR_L: next_pc = pc + {{(ALEN-LIT_W){literal[LIT_W-1]}}, literal};
            OP_BRNZ: begin
                if (rt_data != '0) begin
                    next_pc = rs_data[ALEN-1:0];   // Jump to rd
                end
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------------
    // FSM and PC
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= ST_FETCH;
            pc           <= RESET_PC;
            fetch_start  <= 1'b0;
            fetch_issued <= 1'b0;
            ls_start     <= 1'b0;
        end else begin
            fetch_start <= 1'b0;   // Starts are single-cycle pulses
            ls_start    <= 1'b0;
            case (state)
                ST_FETCH: begin
                    if (fetch_start) begin
                        fetch_issued <= 1'b1;
                    end else if (!fetch_issued) begin
                        fetch_start <= 1'b1;   // First fetch out of reset
                    end
                    if (fetch_done) begin
                        fetch_issued <= 1'b0;
                        state        <= ST_DECODE;
                    end
                end
                ST_DECODE:  state <= ST_EXECUTE;
                ST_EXECUTE: begin
                    ls_start <= is_mem;
                    state    <= ST_MEMORY;
                end
                ST_MEMORY: begin
                    if (!is_mem || ls_done) begin
                        state <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    pc <= next_pc;
                    if (opcode == OP_HALT) begin
                        state <= ST_HALT;
                    end else begin
                        state       <= ST_FETCH;
                        fetch_start <= 1'b1;   // Saves a cycle on the next fetch
                    end
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (state == ST_EXECUTE) begin
            result_q <= alu_result;
        end
    end

    // ------------------------------------------------------------------------
    // Write-back
    // ------------------------------------------------------------------------
    assign wb_en   = (state == ST_WRITEBACK) && writes_rd;
    assign wb_addr = rd;
    assign wb_data = (opcode == OP_LOAD) ? load_data : result_q;  // Loaded word held in LSU
    assign hlt     = (state == ST_HALT);

endmodule

/* rtl/tinker_core.sv */
// Tinker multicycle core top level with control, register file, ALU and memory units
module tinker_core #(
    parameter tinker_pkg::addr_t RESET_PC = 32'h0000_2000
) (
    input  logic              clk,
    input  logic              reset,
    // External memory port
    output logic              mem_req,
    output logic              mem_we,
    output tinker_pkg::addr_t mem_addr,    // 8-aligned
    output tinker_pkg::word_t mem_wdata,
    input  logic              mem_ready,
    input  tinker_pkg::word_t mem_rdata,
    output logic              hlt
);
    import tinker_pkg::*;

    // Decode and register file
    instr_t     instr;
    opcode_e    opcode;
    logic [LIT_W-1:0] literal;
    addr_t      pc;
    reg_addr_t  rf_addr_a;
    reg_addr_t  rf_addr_b;
    word_t      data_a;
    word_t      data_b;
    word_t      alu_result;
    logic       wb_en;
    reg_addr_t  wb_addr;
    word_t      wb_data;

    // Fetch side
    logic       fetch_start;
    logic       f_req;
    addr_t      f_addr;
    logic       f_done;

    // Load/store side
    logic       ls_start;
    logic       ls_store;
    logic       d_req;
    logic       d_we;
    addr_t      d_addr;
    word_t      d_wdata;
    logic       d_done;
    word_t      load_data;

    tinker_control #(.RESET_PC(RESET_PC)) u_control (
        .clk(clk), .reset(reset),
        .instr(instr), .fetch_done(f_done), .fetch_start(fetch_start),
        .rs_data(data_a), .rt_data(data_b),
        .rf_addr_a(rf_addr_a), .rf_addr_b(rf_addr_b),
        .alu_result(alu_result), .load_data(load_data),
        .ls_done(d_done), .ls_start(ls_start), .ls_store(ls_store),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .opcode(opcode), .literal(literal), .pc(pc), .hlt(hlt)
    );

    tinker_regfile u_regfile (
        .clk(clk), .reset(reset),
        .addr_a(rf_addr_a), .addr_b(rf_addr_b),
        .data_a(data_a), .data_b(data_b),
        .we(wb_en), .waddr(wb_addr), .wdata(wb_data)
    );

    tinker_alu u_alu (
        .opcode(opcode), .op_a(data_a), .op_b(data_b),
        .literal(literal), .result(alu_result)
    );

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .start(fetch_start), .pc(pc),
        .req(f_req), .addr(f_addr), .rdata(mem_rdata), .done(f_done),
        .instr(instr)
    );

    load_store_unit u_lsu (
        .clk(clk), .reset(reset), .start(ls_start), .store(ls_store),
        .base(data_a), .literal(literal), .store_data(data_b),
        .req(d_req), .we(d_we), .addr(d_addr), .wdata(d_wdata),
        .rdata(mem_rdata), .done(d_done), .load_data(load_data)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .f_req(f_req), .f_addr(f_addr), .f_done(f_done),
        .d_req(d_req), .d_we(d_we), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_done(d_done),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready)
    );

endmodule

/* verif/tinker_checker.sv */
// Bound assertions on the memory handshake and the halt output of tinker_core
module tinker_checker (
    input logic              clk,
    input logic              reset,
    input logic              mem_req,
    input logic              mem_we,
    input tinker_pkg::addr_t mem_addr,
    input tinker_pkg::word_t mem_wdata,
    input logic              mem_ready,
    input logic              hlt
);
    timeunit 1ns;
    timeprecision 100ps;

    // Request fields hold while the memory stalls
    req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ready |=> mem_req && $stable(mem_we) && $stable(mem_addr)
            && $stable(mem_wdata))
        else $error("memory request changed before mem_ready");

    hlt_sticky: assert property (@(posedge clk) disable iff (reset) !$fell(hlt))
        else $error("hlt fell without reset");

    no_req_halted: assert property (@(posedge clk) disable iff (reset) !(mem_req && hlt))
        else $error("memory request while halted");

    addr_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_req |-> mem_addr[2:0] == 3'b000)
        else $error("mem_addr not 8-aligned");

endmodule

bind tinker_core tinker_checker u_checker (
    .clk(clk), .reset(reset), .mem_req(mem_req), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready), .hlt(hlt)
);

/* verif/tinker_tb.sv */
// Testbench for tinker_core with memory model, program generator, reference model and checks
module tinker_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import tinker_pkg::*;

    localparam addr_t RESET_PC = 32'h0000_2000;
    localparam addr_t DATA_BASE = 32'h0000_0400;   // Preset load words
    localparam addr_t RES_BASE = 32'h0000_0600;    // Result area for stores

    logic  clk;
    logic  reset;
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_ready;
    word_t mem_rdata;
    logic  hlt;

    word_t      mem [addr_t];        // Sparse memory
    word_t      data_init [addr_t];  // Preset data words
    instr_t     prog [$];
    addr_t      exp_addr [$];
    word_t      exp_data [$];
    logic [15:0] lfsr_q = 16'd10518;
    bit         ready_always = 1'b1;
    bit         aborted = 1'b0;
    int         err_value = 0;
    int         err_other = 0;

    tinker_core #(.RESET_PC(RESET_PC)) dut (
        .clk(clk), .reset(reset),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .hlt(hlt)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------------
    // Fibonacci LFSR with taps 16, 14, 13 and 11
    // ------------------------------------------------------------------------
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};   // One step per bit
        end
        return v;
    endfunction

    // Unwritten words read back as an address-dependent pattern
    function automatic word_t mem_read(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {~a, a};
    endfunction

    // ------------------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        mem_ready = ready_always ? 1'b1 : lfsr_step();
        mem_rdata = mem_read(mem_addr);   // Stable before the next rising edge
    end

    always @(posedge clk) begin
        if (!reset && mem_req && mem_ready && mem_we) begin
            mem[mem_addr] = mem_wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            err_value++;
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            err_value++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            err_value++;
        end
    endtask

    // Each completed store against the next predicted one
    always @(posedge clk) begin
        if (!reset && mem_req && mem_ready && mem_we) begin
            if (exp_addr.size() == 0) begin
                $display("A store to 0x%h happened that the model did not predict", mem_addr);
                err_other++;
            end else begin
                check_addr("mem_addr", mem_addr, exp_addr.pop_front());
                check_word("mem_wdata", mem_wdata, exp_data.pop_front());
            end
        end
    end

    // ------------------------------------------------------------------------
    // Program building
    // ------------------------------------------------------------------------
    function automatic instr_t enc(opcode_e op, int rd, int rs, int rt, logic [11:0] lit);
        return {5'(op), 5'(rd), 5'(rs), 5'(rt), lit};
    endfunction

    // r0 included, its write must be dropped
    function automatic void emit_setup();
        for (int r = 0; r < 32; r++) begin
            prog.push_back(enc(OP_MOV_L, r, 0, 0, 12'(rand_bits(12))));
        end
    endfunction

    function automatic void emit_alu(int count);
        opcode_e ops [14];
        opcode_e op;
        logic [11:0] lit;
        ops = '{OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_AND, OP_OR, OP_XOR, OP_NOT,
                OP_SHFTR, OP_SHFTRI, OP_SHFTL, OP_SHFTLI, OP_MOV_R, OP_MOV_L};
        for (int i = 0; i < count; i++) begin
            op = ops[int'(rand_bits(4)) % 14];
            lit = 12'(rand_bits(12));
            if (op == OP_SHFTRI || op == OP_SHFTLI) begin
                lit = 12'(rand_bits(6));   // Shift amount below 64
            end
            // rd may be r0, which must stay zero
            prog.push_back(enc(op, int'(rand_bits(5)), int'(rand_bits(5)),
                               int'(rand_bits(5)), lit));
        end
    endfunction

    function automatic void emit_loads();
        for (int k = 0; k < 4; k++) begin
            data_init[DATA_BASE + addr_t'(8 * k)] = rand_bits(64);
            prog.push_back(enc(OP_LOAD, 1 + int'(rand_bits(4)), 0, 0,
                               12'(DATA_BASE + 8 * k)));
        end
    endfunction

    // Stores of r0..r31, then halt
    function automatic void emit_tail();
        for (int r = 0; r < 32; r++) begin
            prog.push_back(enc(OP_STORE, 0, r, 0, 12'(RES_BASE + 8 * r)));
        end
        prog.push_back(enc(OP_HALT, 0, 0, 0, 12'h000));
    endfunction

    function automatic void emit_branches();
        prog.push_back(enc(OP_MOV_L, 1, 0, 0, 12'(RESET_PC >> 12)));
        prog.push_back(enc(OP_SHFTLI, 1, 0, 0, 12'd12));     // r1 = RESET_PC
        prog.push_back(enc(OP_ADDI, 1, 0, 0, 12'd32));       // Target is index 8
        prog.push_back(enc(OP_MOV_L, 2, 0, 0, 12'h005));
        prog.push_back(enc(OP_BRR_L, 0, 0, 0, 12'd8));       // Skips index 5
        prog.push_back(enc(OP_STORE, 0, 2, 0, 12'h700));
        prog.push_back(enc(OP_BRNZ, 1, 2, 0, 12'h000));      // Taken
        prog.push_back(enc(OP_STORE, 0, 2, 0, 12'h708));
        prog.push_back(enc(OP_BRNZ, 1, 0, 0, 12'h000));      // r0 is zero, falls through
        prog.push_back(enc(OP_STORE, 0, 2, 0, 12'h710));
    endfunction

    // ------------------------------------------------------------------------
    // Reference model of the kept ISA
    // ------------------------------------------------------------------------
    function automatic void run_reference();
        word_t r [32];
        word_t dmem [addr_t];
        addr_t pc;
        addr_t npc;
        addr_t ea;
        instr_t ins;
        int idx;
        int rd;
        int rs;
        int rt;
        logic [11:0] lit;
        word_t sx;
        exp_addr.delete();
        exp_data.delete();
        foreach (r[i]) r[i] = '0;
        foreach (data_init[a]) dmem[a] = data_init[a];
        pc = RESET_PC;
        for (int step = 0; step < 10000; step++) begin
            idx = int'((pc - RESET_PC) >> 2);
            ins = (idx >= 0 && idx < prog.size()) ? prog[idx] : '0;
            rd = ins[26:22];
            rs = ins[21:17];
            rt = ins[16:12];
            lit = ins[11:0];
            sx = {{52{lit[11]}}, lit};
            npc = pc + 4;
            if (ins[31:27] == 5'(OP_HALT)) begin
                break;
            end
            case (ins[31:27])
                5'(OP_ADD):    r[rd] = r[rs] + r[rt];
                5'(OP_ADDI):   r[rd] = r[rd] + sx;
                5'(OP_SUB):    r[rd] = r[rs] - r[rt];
                5'(OP_SUBI):   r[rd] = r[rd] - {52'd0, lit};
                5'(OP_AND):    r[rd] = r[rs] & r[rt];
                5'(OP_OR):     r[rd] = r[rs] | r[rt];
                5'(OP_XOR):    r[rd] = r[rs] ^ r[rt];
                5'(OP_NOT):    r[rd] = ~r[rs];
                5'(OP_SHFTR):  r[rd] = r[rs] >> r[rt];
                5'(OP_SHFTRI): r[rd] = r[rd] >> lit;
                5'(OP_SHFTL):  r[rd] = r[rs] << r[rt];
                5'(OP_SHFTLI): r[rd] = r[rd] << lit;
                5'(OP_MOV_R):  r[rd] = r[rs];
                5'(OP_MOV_L):  r[rd] = {r[rd][63:12], lit};
                5'(OP_LOAD): begin
                    ea = (r[rs][31:0] + sx[31:0]) & ~addr_t'(7);
                    r[rd] = dmem.exists(ea) ? dmem[ea] : {~ea, ea};
                end
                5'(OP_STORE): begin
                    ea = (r[rd][31:0] + sx[31:0]) & ~addr_t'(7);
                    dmem[ea] = r[rs];
                    exp_addr.push_back(ea);
                    exp_data.push_back(r[rs]);
                end
                5'(OP_BRR_L):  npc = pc + sx[31:0];
                5'(OP_BRNZ):   if (r[rs] != 0) npc = r[rd][31:0];
                default: ;     // Unknown opcode does nothing
            endcase
            r[0] = '0;
            pc = npc;
        end
    endfunction

    // ------------------------------------------------------------------------
    // Run one program
    // ------------------------------------------------------------------------
    task automatic load_memory();
        addr_t a;
        word_t w;
        mem.delete();
        foreach (data_init[k]) mem[k] = data_init[k];
        foreach (prog[i]) begin
            a = RESET_PC + addr_t'(4 * i);
            w = mem.exists(a & ~addr_t'(7)) ? mem[a & ~addr_t'(7)] : '0;
            if (a[2]) w[31:0] = prog[i];
            else w[63:32] = prog[i];      // Big-endian upper half
            mem[a & ~addr_t'(7)] = w;
        end
    endtask

    task automatic run_program(bit high_ready);
        int cnt;
        @(posedge clk);
        ready_always = high_ready;
        @(negedge clk);
        reset = 1'b1;
        load_memory();
        run_reference();
        repeat (5) begin
            @(negedge clk);
            check_bit("hlt", hlt, 1'b0);
            check_bit("mem_req", mem_req, 1'b0);
        end
        reset = 1'b0;
        // First request goes to the reset PC
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!mem_req && cnt < 100);
        if (!mem_req) begin
            $display("Timeout waiting for the first memory request");
            err_other++;
            aborted = 1'b1;
            return;
        end
        check_addr("mem_addr", mem_addr, RESET_PC & ~addr_t'(7));
        check_bit("hlt", hlt, 1'b0);
        cnt = 0;
        while (!hlt && cnt < 50000) begin
            @(negedge clk);
            cnt++;
        end
        if (!hlt) begin
            $display("Timeout waiting for hlt");
            err_other++;
            aborted = 1'b1;
            return;
        end
        repeat (3) @(negedge clk);
        check_bit("hlt", hlt, 1'b1);
        if (exp_addr.size() != 0) begin
            $display("%0d predicted stores never happened", exp_addr.size());
            err_other++;
        end
        @(posedge clk);
        ready_always = 1'b1;
    endtask

    task automatic new_program();
        prog.delete();
        data_init.delete();
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        mem_ready = 1'b0;
        mem_rdata = '0;
        @(posedge clk);

        new_program();          // Random ALU only
        emit_setup();
        emit_alu(40);
        emit_tail();
        if (!aborted) run_program(1'b1);
        if (!aborted) run_program(1'b0);

        @(posedge clk);
        new_program();          // ALU with loads
        emit_setup();
        emit_alu(20);
        emit_loads();
        emit_alu(10);
        emit_tail();
        if (!aborted) run_program(1'b1);
        if (!aborted) run_program(1'b0);

        @(posedge clk);
        new_program();          // Branches
        emit_branches();
        emit_tail();
        if (!aborted) run_program(1'b1);
        if (!aborted) run_program(1'b0);

        $display("value errors %0d, other errors %0d", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
rtl/tinker_pkg.sv
rtl/tinker_alu.sv
rtl/tinker_regfile.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/mem_arbiter.sv
rtl/tinker_control.sv
rtl/tinker_core.sv
verif/tinker_checker.sv
verif/tinker_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the tinker_core simulation with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tinker_tb -f sim.f -o tinker_sim \
    || exit 1
./obj_dir/tinker_sim > sim.log 2>&1 || true
cat sim.log
grep -qx '>>> PASS' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
